//--- include/mmio_consts.svh
// mmio constants: bus width, device addresses, info-area mask and index width, mtimecmp reset
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// data and address width of the core bus
`define MMIO_XLEN 64

// real-time counter, read only, free running from reset
`define MMIO_DEV_RTC 64'h0000_0000_a100_0048

// core-local interruptor registers, both full 64-bit words
`define MMIO_DEV_MTIME 64'h0000_0000_0200_bff8
`define MMIO_DEV_MTIMECMP 64'h0000_0000_0200_4000

// information area, 16 words selected by the low address bits
`define MMIO_DEV_INFO 64'h0000_0000_0200_8000
`define MMIO_DEV_INFO_MASK 64'hffff_ffff_ffff_fff0
`define MMIO_INFO_IDX_W 4

// all ones keeps the timer quiet until software programs a compare value
`define MMIO_MTIMECMP_RST 64'hffff_ffff_ffff_ffff

`endif

//--- hdl/mmio_pkg.sv
// mmio package: address union, device-select enum, stage request and response structs
`default_nettype none

`include "mmio_consts.svh"

package mmio_pkg;

  // one address word seen two ways, raw for the timers and tag plus index for the info area
  typedef union packed {
    logic [`MMIO_XLEN-1:0] raw;  // full device address
    struct packed {
      logic [`MMIO_XLEN-`MMIO_INFO_IDX_W-1:0] tag;  // info-area base bits
      logic [`MMIO_INFO_IDX_W-1:0] idx;  // word index into the info table
    } info;
  } mmio_addr_u;

  // device picked by the decode stage
  typedef enum logic [2:0] {
    DEV_NONE,  // unmapped, reads give zero and writes are dropped
    DEV_RTC,  // real-time counter
    DEV_MTIME,  // timer count
    DEV_MTIMECMP,  // timer compare
    DEV_INFO  // read-only string area
  } mmio_dev_e;

  // stage 1 output, one registered access
  typedef struct packed {
    logic valid;  // access present this cycle
    logic ren;  // load
    logic wen;  // store
    mmio_dev_e dev;  // decoded target
    mmio_addr_u addr;  // address as issued by the core
    logic [`MMIO_XLEN-1:0] wdata;  // store data, full word only
  } mmio_req_s;

  // stage 2 output, merged device data for the response stage
  typedef struct packed {
    logic valid;  // access completed its device cycle
    logic ren;  // data belongs to a load
    logic [`MMIO_XLEN-1:0] rdata;  // OR of all device read data
  } mmio_rsp_s;

endpackage

`default_nettype wire

//--- hdl/mmio_decode.sv
// mmio_decode: stage 1 request register and address-to-device classification
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_decode (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_start,  // one-cycle strobe from the memory stage
  input  wire                   i_ren,
  input  wire                   i_wen,
  input  wire [`MMIO_XLEN-1:0]  i_addr,
  input  wire [`MMIO_XLEN-1:0]  i_wdata,
  output mmio_pkg::mmio_req_s   o_req  // registered access for stage 2
);

  import mmio_pkg::*;

  mmio_addr_u addr_in;  // incoming address in union form
  mmio_dev_e  dev_sel;  // combinational classification

  assign addr_in.raw = i_addr;  // the union carries the raw word through unchanged

  // timers need an exact match, the info area only its base bits
  always_comb begin
    if (addr_in.raw == `MMIO_DEV_RTC) begin
      dev_sel = DEV_RTC;
    end else if (addr_in.raw == `MMIO_DEV_MTIME) begin
      dev_sel = DEV_MTIME;
    end else if (addr_in.raw == `MMIO_DEV_MTIMECMP) begin
      dev_sel = DEV_MTIMECMP;
    end else if ((addr_in.raw & `MMIO_DEV_INFO_MASK) == `MMIO_DEV_INFO) begin
      dev_sel = DEV_INFO;  // any of the 16 words
    end else begin
      dev_sel = DEV_NONE;  // nothing mapped here
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req.valid <= 1'b0;  // no access in flight after reset
      o_req.ren   <= 1'b0;
      o_req.wen   <= 1'b0;
    end else begin
      o_req.valid <= i_start;  // valid lasts exactly one cycle per start
      o_req.ren   <= i_start & i_ren;
      o_req.wen   <= i_start & i_wen;
    end
    if (i_start) begin
      o_req.dev   <= dev_sel;  // payload is captured only with a start
      o_req.addr  <= addr_in;
      o_req.wdata <= i_wdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mmio_timer_bank.sv
// mmio_timer_bank: stage 2 rtc, mtime and mtimecmp registers, timer read data and pending flag
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_timer_bank (
  input  wire                   clk,
  input  wire                   rst,
  input  wire mmio_pkg::mmio_req_s i_req,  // access from the decode stage
  output logic [`MMIO_XLEN-1:0] o_rdata,  // zero unless a timer read was served
  output logic                  o_mtime_pending  // registered mtime >= mtimecmp
);

  import mmio_pkg::*;

  localparam logic [`MMIO_XLEN-1:0] TICK = {{(`MMIO_XLEN-1){1'b0}}, 1'b1};  // one count per clock

  logic [`MMIO_XLEN-1:0] rtc_q;  // free-running real-time count
  logic [`MMIO_XLEN-1:0] rtc_nxt;
  logic [`MMIO_XLEN-1:0] mtime_q;  // timer count, software may overwrite it
  logic [`MMIO_XLEN-1:0] mtime_nxt;
  logic [`MMIO_XLEN-1:0] mtimecmp_q;  // timer compare value
  logic                  rd_hit;  // valid load this cycle
  logic                  wr_mtime;  // valid store to mtime
  logic                  wr_mtimecmp;  // valid store to mtimecmp

  assign rd_hit      = i_req.valid & i_req.ren;
  assign wr_mtime    = i_req.valid & i_req.wen & (i_req.dev == DEV_MTIME);
  assign wr_mtimecmp = i_req.valid & i_req.wen & (i_req.dev == DEV_MTIMECMP);

  // a store replaces the count, otherwise both counters step by one
  assign rtc_nxt   = rtc_q + TICK;  // stores to the rtc address never reach it
  assign mtime_nxt = wr_mtime ? i_req.wdata : mtime_q + TICK;

  always_ff @(posedge clk) begin
    if (rst) begin
      rtc_q           <= '0;
      mtime_q         <= '0;
      mtimecmp_q      <= `MMIO_MTIMECMP_RST;  // nothing pending out of reset
      o_mtime_pending <= 1'b0;
    end else begin
      rtc_q   <= rtc_nxt;
      mtime_q <= mtime_nxt;
      if (wr_mtimecmp) begin
        mtimecmp_q <= i_req.wdata;  // new compare value, seen by the flag next cycle
      end
      o_mtime_pending <= (mtime_q >= mtimecmp_q);  // one cycle behind the registers
    end
  end

  // counter reads return the value as it stands after this cycle's update
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      case (i_req.dev)
        DEV_RTC:      o_rdata <= rtc_nxt;
        DEV_MTIME:    o_rdata <= mtime_nxt;
        DEV_MTIMECMP: o_rdata <= mtimecmp_q;
        default:      o_rdata <= '0;  // info or unmapped, another device answers
      endcase
    end else begin
      o_rdata <= '0;  // idle and stores give zero so the top can OR the banks
    end
  end

endmodule

`default_nettype wire

//--- hdl/mmio_info_rom.sv
// mmio_info_rom: stage 2 reset-loaded 16-word identification table and its read port
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_info_rom (
  input  wire                   clk,
  input  wire                   rst,
  input  wire mmio_pkg::mmio_req_s i_req,  // access from the decode stage
  output logic [`MMIO_XLEN-1:0] o_rdata  // indexed word on an info read, else zero
);

  import mmio_pkg::*;

  localparam int unsigned WORDS = 1 << `MMIO_INFO_IDX_W;  // 16 entries

  logic [`MMIO_XLEN-1:0] info_mem [WORDS];  // string table, byte 0 of each word comes first
  logic                  rd_info;  // valid load aimed at this area

  assign rd_info = i_req.valid & i_req.ren & (i_req.dev == DEV_INFO);

  // "RV64 MMIO SLAVE: RTC, CLINT TIMER AND INFO AREA\nTHREE-STAGE REQ/ACK PIPELINE, REV 1.0\n"
  // eight characters per word, first character in the low byte, NUL ends the text in word 10
  always_ff @(posedge clk) begin
    if (rst) begin
      info_mem[0]  <= 64'h49_4D_4D_20_34_36_56_52;  // RV64 MMI
      info_mem[1]  <= 64'h3A_45_56_41_4C_53_20_4F;  // O SLAVE:
      info_mem[2]  <= 64'h4C_43_20_2C_43_54_52_20;  // " RTC, CL"
      info_mem[3]  <= 64'h45_4D_49_54_20_54_4E_49;  // INT TIME
      info_mem[4]  <= 64'h4E_49_20_44_4E_41_20_52;  // R AND IN
      info_mem[5]  <= 64'h0A_41_45_52_41_20_4F_46;  // FO AREA and newline
      info_mem[6]  <= 64'h54_53_2D_45_45_52_48_54;  // THREE-ST
      info_mem[7]  <= 64'h2F_51_45_52_20_45_47_41;  // AGE REQ/
      info_mem[8]  <= 64'h45_50_49_50_20_4B_43_41;  // ACK PIPE
      info_mem[9]  <= 64'h45_52_20_2C_45_4E_49_4C;  // LINE, RE
      info_mem[10] <= 64'h00_00_0A_30_2E_31_20_56;  // V 1.0, newline and terminator
      for (int i = 11; i < WORDS; i++) begin
        info_mem[i] <= '0;  // unused tail reads back as zero
      end
    end
  end

  // the info view of the address supplies the word index directly
  always_ff @(posedge clk) begin
    if (rd_info) begin
      o_rdata <= info_mem[i_req.addr.info.idx];
    end else begin
      o_rdata <= '0;  // stays out of the way of the timer data
    end
  end

endmodule

`default_nettype wire

//--- hdl/mmio_respond.sv
// mmio_respond: stage 3 response register with req/ack hold and clear
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_respond (
  input  wire                   clk,
  input  wire                   rst,
  input  wire mmio_pkg::mmio_rsp_s i_rsp,  // merged device result from stage 2
  input  wire                   i_ack,  // core has taken the response
  output logic                  o_req,  // response pending toward the core
  output logic [`MMIO_XLEN-1:0] o_rdata  // load data, zero for stores
);

  import mmio_pkg::*;

  logic take_ack;  // ack seen while a response is pending

  assign take_ack = o_req & i_ack;

  // the core only starts again after its ack, so a new result never lands on a pending one
  always_ff @(posedge clk) begin
    if (rst) begin
      o_req   <= 1'b0;
      o_rdata <= '0;
    end else if (i_rsp.valid) begin
      o_req   <= 1'b1;  // rises three cycles after the start strobe
      o_rdata <= i_rsp.ren ? i_rsp.rdata : '0;  // stores answer with zero data
    end else if (take_ack) begin
      o_req   <= 1'b0;  // both clear on the cycle after the ack
      o_rdata <= '0;
    end
    // with no ack the response simply holds
  end

endmodule

`default_nettype wire

//--- hdl/mmio_top.sv
// mmio_top: mmio slave top level chaining decode, timer bank, info table and response stages
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_start,  // access strobe from the memory stage
  input  wire                   i_ack,  // response accepted
  input  wire                   i_ren,
  input  wire                   i_wen,
  input  wire [`MMIO_XLEN-1:0]  i_addr,
  input  wire [`MMIO_XLEN-1:0]  i_wdata,
  output logic                  o_req,  // response pending
  output logic [`MMIO_XLEN-1:0] o_rdata,
  output logic                  o_mtime_pending  // timer interrupt request
);

  import mmio_pkg::*;

  mmio_req_s             req_s1;  // decode stage output
  mmio_rsp_s             rsp_s2;  // device stage output
  logic [`MMIO_XLEN-1:0] timer_rdata;  // zero unless a timer was read
  logic [`MMIO_XLEN-1:0] info_rdata;  // zero unless the info area was read
  logic                  s2_valid;  // request valid delayed to line up with device data
  logic                  s2_ren;

  mmio_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .i_start (i_start),
    .i_ren   (i_ren),
    .i_wen   (i_wen),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_req   (req_s1)
  );

  mmio_timer_bank u_timer_bank (
    .clk             (clk),
    .rst             (rst),
    .i_req           (req_s1),
    .o_rdata         (timer_rdata),
    .o_mtime_pending (o_mtime_pending)
  );

  mmio_info_rom u_info_rom (
    .clk     (clk),
    .rst     (rst),
    .i_req   (req_s1),
    .o_rdata (info_rdata)
  );

  // device data is registered, so the control bits take the same one-cycle step
  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
      s2_ren   <= 1'b0;
    end else begin
      s2_valid <= req_s1.valid;
      s2_ren   <= req_s1.valid & req_s1.ren;
    end
  end

  assign rsp_s2.valid = s2_valid;
  assign rsp_s2.ren   = s2_ren;
  assign rsp_s2.rdata = timer_rdata | info_rdata;  // at most one bank is nonzero

  mmio_respond u_respond (
    .clk     (clk),
    .rst     (rst),
    .i_rsp   (rsp_s2),
    .i_ack   (i_ack),
    .o_req   (o_req),
    .o_rdata (o_rdata)
  );

endmodule

`default_nettype wire

//--- tb/mmio_checker.sv
// mmio_checker: monitor of the mmio slave ports comparing responses with the tests file
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_checker (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  i_start,
  input  wire                  i_ack,
  input  wire                  i_rsp_req,  // UUT o_req
  input  wire [`MMIO_XLEN-1:0] i_rsp_rdata,  // UUT o_rdata
  input  wire                  i_mtime_pending,
  output int                   o_errors,
  output int                   o_checked
);

  logic [7:0]            op_q[$];
  logic [`MMIO_XLEN-1:0] addr_q[$];
  logic [`MMIO_XLEN-1:0] wdata_q[$];
  logic [7:0]            kind_q[$];  // E exact, D delta, N none
  logic [`MMIO_XLEN-1:0] exp_q[$];
  logic [7:0]            pend_q[$];  // expected timer flag, 0, 1 or - for no check

  int                    cycle = 0;  // counted on falling edges out of reset
  int                    starts = 0;
  int                    start_cycle = 0;  // start of the access now in flight
  int                    mtime_cycle = 0;  // start of the last mtime write
  int                    rtc_cycle = 0;  // start of the last rtc read
  logic [`MMIO_XLEN-1:0] mtime_base = '0;
  logic [`MMIO_XLEN-1:0] rtc_base = '0;
  logic [`MMIO_XLEN-1:0] held = '0;  // data captured when the response rose
  logic                  req_prev = 1'b0;
  logic                  ack_taken = 1'b0;  // ack was visible with a pending response

  task automatic load_expectations();
    int                    fd;
    string                 line;
    logic [7:0]            op;
    logic [7:0]            kind;
    logic [7:0]            pend;
    logic [`MMIO_XLEN-1:0] addr;
    logic [`MMIO_XLEN-1:0] wdata;
    logic [`MMIO_XLEN-1:0] expv;
    fd = $fopen("tb/mmio_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/mmio_tests.txt for the expectations");
      o_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%c %h %h %c %h %c", op, addr, wdata, kind, expv, pend) == 6) begin
          op_q.push_back(op);
          addr_q.push_back(addr);
          wdata_q.push_back(wdata);
          kind_q.push_back(kind);
          exp_q.push_back(expv);
          pend_q.push_back(pend);
        end
      end
    end
    $fclose(fd);
  endtask

  // an mtime write sets the base for later delta reads of mtime
  task automatic note_start();
    if (starts >= op_q.size()) begin
      $display("start strobe at %0t with no test line left", $time);
      o_errors++;
      return;
    end
    start_cycle = cycle;
    if (op_q[starts] == "W" && addr_q[starts] == `MMIO_DEV_MTIME) begin
      mtime_base  = wdata_q[starts];
      mtime_cycle = cycle;
    end
    starts++;
  endtask

  task automatic check_response();
    int                    n;
    logic [`MMIO_XLEN-1:0] expv;
    n = o_checked;
    if (n >= op_q.size()) begin
      $display("response at %0t with no test line left", $time);
      o_errors++;
      return;
    end
    if (cycle - start_cycle != 3) begin
      $display("Mismatch at %0t: line %0d response came %0d cycles after start, not 3",
               $time, n, cycle - start_cycle);
      o_errors++;
    end
    expv = exp_q[n];
    if (kind_q[n] == "D") begin  // counters move one per cycle between starts
      if (addr_q[n] == `MMIO_DEV_MTIME) begin
        expv = mtime_base + 64'(start_cycle - mtime_cycle);
      end else begin
        expv = rtc_base + 64'(start_cycle - rtc_cycle);
      end
    end
    if (kind_q[n] != "N" && i_rsp_rdata !== expv) begin
      $display("Mismatch at %0t: line %0d read data %h, expected %h", $time, n, i_rsp_rdata, expv);
      o_errors++;
    end
    if (pend_q[n] != "-" && i_mtime_pending !== (pend_q[n] == "1")) begin
      $display("Mismatch at %0t: line %0d timer pending %b, expected %c",
               $time, n, i_mtime_pending, pend_q[n]);
      o_errors++;
    end
    if (op_q[n] == "R" && addr_q[n] == `MMIO_DEV_RTC) begin
      rtc_base  = i_rsp_rdata;  // next rtc delta counts from here
      rtc_cycle = start_cycle;
    end
    held = i_rsp_rdata;
    o_checked++;
  endtask

  initial begin
    o_errors  = 0;
    o_checked = 0;
    load_expectations();
  end

  // falling edge sampling keeps clear of the UUT updates and of the 1 ns drive delay
  always @(negedge clk) begin
    if (rst) begin
      cycle     = 0;
      req_prev  = 1'b0;
      ack_taken = 1'b0;
      if (i_rsp_req !== 1'b0 || i_rsp_rdata !== '0 || i_mtime_pending !== 1'b0) begin
        $display("Mismatch at %0t: outputs not cleared by reset", $time);
        o_errors++;
      end
    end else begin
      cycle = cycle + 1;
      if (ack_taken && (i_rsp_req !== 1'b0 || i_rsp_rdata !== '0)) begin
        $display("Mismatch at %0t: response not cleared on the cycle after ack", $time);
        o_errors++;
      end
      if (req_prev && !i_rsp_req && !ack_taken) begin  // only an ack may end a response
        $display("Mismatch at %0t: response dropped before any ack", $time);
        o_errors++;
      end
      ack_taken = 1'b0;
      if (i_start) note_start();
      if (i_rsp_req && !req_prev) begin
        check_response();
      end else if (i_rsp_req && i_rsp_rdata !== held) begin
        $display("Mismatch at %0t: read data changed to %h while pending", $time, i_rsp_rdata);
        o_errors++;
      end
      if (i_rsp_req && i_ack) ack_taken = 1'b1;
      req_prev = i_rsp_req;
    end
  end

endmodule

`default_nettype wire

//--- tb/mmio_tb.sv
// mmio_tb: testbench top with clock, reset, file-driven accesses, UUT, checker, timeout and report
`timescale 1ns/10ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_tb;

  logic                  clk;
  logic                  rst;
  logic                  i_start;  // one-cycle access strobe
  logic                  i_ack;  // response taken
  logic                  i_ren;
  logic                  i_wen;
  logic [`MMIO_XLEN-1:0] i_addr;
  logic [`MMIO_XLEN-1:0] i_wdata;
  logic                  o_req;
  logic [`MMIO_XLEN-1:0] o_rdata;
  logic                  o_mtime_pending;

  int errors;  // reported by the checker
  int checked;  // responses the checker has compared
  int cycles = 0;  // free-running count for the timeout
  int cycle_limit = 0;  // stays zero until the tests are loaded

  logic [7:0]            op_q[$];  // R or W per test line
  logic [`MMIO_XLEN-1:0] addr_q[$];
  logic [`MMIO_XLEN-1:0] wdata_q[$];

  mmio_top UUT (
    .clk             (clk),
    .rst             (rst),
    .i_start         (i_start),
    .i_ack           (i_ack),
    .i_ren           (i_ren),
    .i_wen           (i_wen),
    .i_addr          (i_addr),
    .i_wdata         (i_wdata),
    .o_req           (o_req),
    .o_rdata         (o_rdata),
    .o_mtime_pending (o_mtime_pending)
  );

  mmio_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .i_start         (i_start),
    .i_ack           (i_ack),
    .i_rsp_req       (o_req),
    .i_rsp_rdata     (o_rdata),
    .i_mtime_pending (o_mtime_pending),
    .o_errors        (errors),
    .o_checked       (checked)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the accesses did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // only the stimulus columns matter here, the checker reads the expectations itself
  task automatic load_stimulus();
    int                    fd;
    string                 line;
    logic [7:0]            op;
    logic [7:0]            kind;
    logic [7:0]            pend;
    logic [`MMIO_XLEN-1:0] addr;
    logic [`MMIO_XLEN-1:0] wdata;
    logic [`MMIO_XLEN-1:0] expv;
    fd = $fopen("tb/mmio_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/mmio_tests.txt for the stimulus");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin  // skip blanks and column notes
        if ($sscanf(line, "%c %h %h %c %h %c", op, addr, wdata, kind, expv, pend) == 6) begin
          op_q.push_back(op);
          addr_q.push_back(addr);
          wdata_q.push_back(wdata);
        end
      end
    end
    $fclose(fd);
  endtask

  // one full access: strobe, wait for the response, ack one cycle later, wait for the clear
  task automatic run_access(input int n);
    @(posedge clk);
    #1;
    i_start = 1'b1;
    i_ren   = (op_q[n] == "R");
    i_wen   = (op_q[n] == "W");
    i_addr  = addr_q[n];
    i_wdata = wdata_q[n];
    @(posedge clk);
    #1;
    i_start = 1'b0;  // the strobe lasts one cycle
    i_ren   = 1'b0;
    i_wen   = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!o_req);
    @(posedge clk);
    #1;
    i_ack = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (o_req);  // next start only once the response has dropped
    i_ack = 1'b0;
  endtask

  initial begin
    rst     = 1'b1;
    i_start = 1'b0;
    i_ack   = 1'b0;
    i_ren   = 1'b0;
    i_wen   = 1'b0;
    i_addr  = '0;
    i_wdata = '0;
    load_stimulus();
    cycle_limit = op_q.size() * 10 + 100;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      run_access(i);
    end
    repeat (2) @(posedge clk);
    $display("closing report: %0d tests, %0d responses checked, %0d errors",
             op_q.size(), checked, errors);
    if (errors == 0 && op_q.size() > 0 && checked == op_q.size()) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/mmio_tests.txt
# columns: op (R/W), address (hex), write data (hex), kind (E exact, D delta, N none),
# expected data (hex), expected timer pending (0, 1, - unchecked); info words pack LSB first
R a1000048 0 N 0 0
W a1000048 deadbeef E 0 -
R a1000048 0 D 0 -
R 30000000 0 E 0 -
W 0200bff8 1000 E 0 -
W 02004000 1040 E 0 -
R 0200bff8 0 D 0 0
R 02004000 0 E 1040 0
R 02008000 0 E 494D4D2034365652 -
R 02008001 0 E 3A4556414C53204F -
R 02008002 0 E 4C43202C43545220 -
R 02008003 0 E 454D495420544E49 -
R 02008004 0 E 4E4920444E412052 -
R 02008005 0 E 0A41455241204F46 -
R 02008006 0 E 54532D4545524854 -
R 02008007 0 E 2F51455220454741 -
R 02008008 0 E 45504950204B4341 -
R 02008009 0 E 4552202C454E494C -
R 0200800a 0 E 00000A302E312056 -
R 0200800b 0 E 0 -
R 0200800f 0 E 0 -
R 0200bff8 0 D 0 1
W 02004000 ffffffffffffffff E 0 -
R 02004000 0 E ffffffffffffffff 0
R 0200bff8 0 D 0 0

//--- sim.f
+incdir+include
hdl/mmio_pkg.sv
hdl/mmio_decode.sv
hdl/mmio_timer_bank.sv
hdl/mmio_info_rom.sv
hdl/mmio_respond.sv
hdl/mmio_top.sv
tb/mmio_checker.sv
tb/mmio_tb.sv

//--- Makefile
# Verilator build and run for the mmio slave testbench

VERILATOR ?= verilator
TOP       ?= mmio_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
